// File: flist.f
+incdir+source
source/shim_pkg.sv
source/afifo_if.sv
source/async_fifo.sv
source/afu_side.sv
source/bb_side.sv
source/async_shim_top.sv
tests/tb_clkgen.sv
tests/shim_checker.sv
tests/tb_top.sv

// File: Makefile
# Verilator flow for the clock-crossing shim

VERILATOR ?= verilator
TOP       ?= tb_top
SEED      ?= 0
LOG       ?= sim.log
BUILD     ?= obj_dir
FLIST     ?= flist.f

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary --timing --assert -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD)

# Pass or fail is taken from the log, not from the simulator exit code
sim: build
	./$(BUILD)/V$(TOP) +verilator+seed+$(SEED) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: tests/tb_top.sv
`timescale 1ns/1ps

`include "shim_cfg.svh"

module tb_top;

   localparam int REQ_W      = $bits(shim_pkg::req_hdr_t);
   localparam int RSP_HDR_W  = $bits(shim_pkg::rsp_hdr_u);
   localparam int WAIT_LIMIT = 20000;

   logic                     bb_clk;
   logic                     afu_clk;
   logic                     bb_softreset;
   logic                     bb_c0_almfull;
   logic                     bb_rsp_valid;
   logic                     bb_mmio_wr_valid;
   shim_pkg::rsp_hdr_u       bb_rsp_hdr;
   logic [`SHIM_DATA_W-1:0]  bb_rsp_data;
   logic                     afu_c0_req_valid;
   shim_pkg::req_hdr_t       afu_c0_req_hdr;
   logic                     afu_softreset;
   logic                     bb_c0_req_valid;
   shim_pkg::req_hdr_t       bb_c0_req_hdr;
   logic                     afu_c0_almfull;
   logic                     afu_rsp_valid;
   logic                     afu_mmio_wr_valid;
   shim_pkg::rsp_hdr_u       afu_rsp_hdr;
   logic [`SHIM_DATA_W-1:0]  afu_rsp_data;
   logic                     req_overflow;
   logic                     rsp_overflow;

   // Reference model
   shim_pkg::req_hdr_t       exp_req [$];
   logic                     exp_kind [$];
   shim_pkg::rsp_hdr_u       exp_hdr [$];
   logic [`SHIM_DATA_W-1:0]  exp_data [$];

   int errors       = 0;
   int timeouts     = 0;
   int arrived      = 0;
   int mem_sent     = 0;
   int req_ovf_seen = 0;
   int rsp_ovf_seen = 0;

   tb_clkgen clkgen_i (
      .bb_clk       (bb_clk),
      .afu_clk      (afu_clk),
      .bb_softreset (bb_softreset)
   );

   async_shim_top dut_i (.*);

   bind async_shim_top shim_checker checker_i (
      .bb_clk            (bb_clk),
      .bb_softreset      (bb_softreset),
      .afu_clk           (afu_clk),
      .afu_softreset     (afu_softreset),
      .bb_c0_req_valid   (bb_c0_req_valid),
      .afu_rsp_valid     (afu_rsp_valid),
      .afu_mmio_wr_valid (afu_mmio_wr_valid)
   );

   task automatic finish_run();
      $display("Closing counts: %0d check errors, %0d timeouts", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   endtask

   task automatic abort_on_timeout(input string what);
      timeouts++;
      $display("Timeout while waiting for %s", what);
      finish_run();
   endtask

   task automatic check_req(input string name, input shim_pkg::req_hdr_t exp,
                            input shim_pkg::req_hdr_t act);
      if (act !== exp) begin
         errors++;
         $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic check_rsp(input string name, input logic mmio,
                            input shim_pkg::rsp_hdr_u exp_h, input logic [`SHIM_DATA_W-1:0] exp_d,
                            input shim_pkg::rsp_hdr_u act_h, input logic [`SHIM_DATA_W-1:0] act_d);
      logic ok;
      // Only the fields of the view selected by the kind bit matter
      if (mmio) begin
         ok = (act_h.mmio.tid === exp_h.mmio.tid) &&
              (act_h.mmio.mmio_addr === exp_h.mmio.mmio_addr);
      end else begin
         ok = (act_h.mem.tag === exp_h.mem.tag) && (act_h.mem.cl_num === exp_h.mem.cl_num);
      end
      if (!ok || act_d !== exp_d) begin
         errors++;
         $display("CHECK FAILED %s expected %h/%h actual %h/%h", name, exp_h, exp_d, act_h, act_d);
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         errors++;
         $display("CHECK FAILED %s expected %b actual %b", name, exp, act);
      end
   endtask

   // Accelerator request driver
   // Only the first keep requests go into the model
   task automatic send_requests(input int n, input bit obey_almfull, input int keep);
      int sent;
      int idle;
      shim_pkg::req_hdr_t hdr;
      sent = 0;
      idle = 0;
      while (sent < n) begin
         @(posedge afu_clk);
         if ((obey_almfull && afu_c0_almfull) || ($urandom % 3 == 0)) begin
            afu_c0_req_valid <= 1'b0;
            idle++;
            if (idle > WAIT_LIMIT) begin
               abort_on_timeout("afu_c0_almfull to fall");
            end
         end else begin
            hdr = REQ_W'($urandom);
            afu_c0_req_valid <= 1'b1;
            afu_c0_req_hdr   <= hdr;
            if (sent < keep) begin
               exp_req.push_back(hdr);
            end
            sent++;
            idle = 0;
         end
      end
      @(posedge afu_clk);
      afu_c0_req_valid <= 1'b0;
   endtask

   // Host responder sends one memory response per arrived request with MMIO writes mixed in
   task automatic serve_host(input int n_mem, input bit toggle_almfull, input bit allow_mmio);
      int sent;
      int cycles;
      int pick;
      shim_pkg::rsp_hdr_u hdr;
      logic [`SHIM_DATA_W-1:0] data;
      sent = 0;
      cycles = 0;
      while (sent < n_mem) begin
         @(posedge bb_clk);
         pick = $urandom % 4;
         hdr  = RSP_HDR_W'($urandom);
         data = `SHIM_DATA_W'($urandom);
         bb_rsp_valid     <= 1'b0;
         bb_mmio_wr_valid <= 1'b0;
         bb_rsp_hdr       <= hdr;
         bb_rsp_data      <= data;
         if (toggle_almfull) begin
            bb_c0_almfull <= ($urandom % 4 == 0);
         end
         if (allow_mmio && pick == 0) begin
            bb_mmio_wr_valid <= 1'b1;
            exp_kind.push_back(1'b1);
            exp_hdr.push_back(hdr);
            exp_data.push_back(data);
         end else if (pick != 3 && arrived > mem_sent) begin
            bb_rsp_valid <= 1'b1;
            exp_kind.push_back(1'b0);
            exp_hdr.push_back(hdr);
            exp_data.push_back(data);
            mem_sent++;
            sent++;
         end
         cycles++;
         if (cycles > WAIT_LIMIT) begin
            abort_on_timeout("requests to reach the host side");
         end
      end
      @(posedge bb_clk);
      bb_rsp_valid     <= 1'b0;
      bb_mmio_wr_valid <= 1'b0;
      bb_c0_almfull    <= 1'b0;
   endtask

   task automatic wait_almfull(input logic level);
      int cycles;
      cycles = 0;
      while (afu_c0_almfull !== level) begin
         @(negedge afu_clk);
         cycles++;
         if (cycles > WAIT_LIMIT) begin
            abort_on_timeout(level ? "afu_c0_almfull to rise" : "afu_c0_almfull to fall");
         end
      end
   endtask

   task automatic wait_drained();
      int cycles;
      cycles = 0;
      while (exp_req.size() != 0 || exp_kind.size() != 0) begin
         @(negedge bb_clk);
         cycles++;
         if (cycles > WAIT_LIMIT) begin
            abort_on_timeout("expected transfers to drain");
         end
      end
   endtask

   // Host-side monitor
   always @(negedge bb_clk) begin
      if (bb_softreset === 1'b0) begin
         if (rsp_overflow === 1'b1) begin
            rsp_ovf_seen++;
         end
         if (bb_c0_req_valid === 1'b1) begin
            arrived++;
            if (exp_req.size() == 0) begin
               errors++;
               $display("Request arrived on the host side with none expected");
            end else begin
               check_req("req_order", exp_req.pop_front(), bb_c0_req_hdr);
            end
         end
      end
   end

   // Accelerator-side monitor
   always @(negedge afu_clk) begin : afu_monitor
      logic kind;
      if (afu_softreset === 1'b0) begin
         if (req_overflow === 1'b1) begin
            req_ovf_seen++;
         end
         if (afu_rsp_valid === 1'b1 || afu_mmio_wr_valid === 1'b1) begin
            if (exp_kind.size() == 0) begin
               errors++;
               $display("Response arrived on the accelerator side with none expected");
            end else begin
               kind = exp_kind.pop_front();
               check_bit("rsp_kind", kind, afu_mmio_wr_valid);
               check_rsp("rsp_payload", kind, exp_hdr.pop_front(), exp_data.pop_front(),
                         afu_rsp_hdr, afu_rsp_data);
            end
         end
      end
   end

   initial begin : main
      int cycles;
      void'($urandom(32'h1f2c));
      bb_c0_almfull    = 1'b0;
      bb_rsp_valid     = 1'b0;
      bb_mmio_wr_valid = 1'b0;
      bb_rsp_hdr       = '0;
      bb_rsp_data      = '0;
      afu_c0_req_valid = 1'b0;
      afu_c0_req_hdr   = '0;

      // Reset values
      // The synchronized reset must first rise before its fall means anything
      cycles = 0;
      while (afu_softreset !== 1'b1) begin
         @(negedge afu_clk);
         cycles++;
         if (cycles > WAIT_LIMIT) begin
            abort_on_timeout("afu_softreset to rise");
         end
      end
      cycles = 0;
      while (afu_softreset !== 1'b0) begin
         @(negedge afu_clk);
         cycles++;
         if (cycles > WAIT_LIMIT) begin
            abort_on_timeout("afu_softreset to fall");
         end
      end
      @(negedge afu_clk);
      check_bit("reset_bb_req_valid", 1'b0, bb_c0_req_valid);
      check_bit("reset_afu_rsp_valid", 1'b0, afu_rsp_valid);
      check_bit("reset_afu_mmio_valid", 1'b0, afu_mmio_wr_valid);
      check_bit("reset_afu_almfull", 1'b0, afu_c0_almfull);
      check_bit("reset_req_overflow", 1'b0, req_overflow);
      check_bit("reset_rsp_overflow", 1'b0, rsp_overflow);

      // Random traffic both ways with host back-pressure
      fork
         send_requests(200, 1'b1, 200);
         serve_host(200, 1'b1, 1'b1);
      join
      wait_drained();
      check_bit("traffic_req_overflow", 1'b0, req_ovf_seen != 0);

      // Credit limit
      send_requests(17, 1'b0, 17);
      wait_almfull(1'b1);
      serve_host(17, 1'b0, 1'b0);
      wait_almfull(1'b0);
      wait_drained();

      // Overflow of the request FIFO while the host holds it off
      @(posedge bb_clk);
      bb_c0_almfull <= 1'b1;
      repeat (4) @(posedge bb_clk);
      send_requests(20, 1'b0, 16);
      cycles = 0;
      while (req_ovf_seen == 0) begin
         @(negedge afu_clk);
         cycles++;
         if (cycles > WAIT_LIMIT) begin
            abort_on_timeout("req_overflow to pulse");
         end
      end
      check_bit("overflow_rsp_quiet", 1'b0, rsp_ovf_seen != 0);
      @(posedge bb_clk);
      bb_c0_almfull <= 1'b0;
      wait_drained();
      repeat (20) @(posedge bb_clk);
      finish_run();
   end

endmodule

// File: tests/shim_checker.sv
`timescale 1ns/1ps

module shim_checker (
   input logic bb_clk,
   input logic bb_softreset,
   input logic afu_clk,
   input logic afu_softreset,
   input logic bb_c0_req_valid,
   input logic afu_rsp_valid,
   input logic afu_mmio_wr_valid
);

   // Valids are cleared on the first clock edge inside reset
   bb_valid_in_reset: assert property (@(posedge bb_clk) bb_softreset |=> !bb_c0_req_valid)
      else $error("bb_c0_req_valid high while bb_softreset is active");

   afu_valid_in_reset: assert property (@(posedge afu_clk)
      afu_softreset |=> !(afu_rsp_valid || afu_mmio_wr_valid))
      else $error("afu response valid high while afu_softreset is active");

   // A FIFO entry is either a memory response or an MMIO write
   afu_kind_onehot: assert property (@(posedge afu_clk)
      !afu_softreset |-> !(afu_rsp_valid && afu_mmio_wr_valid))
      else $error("afu_rsp_valid and afu_mmio_wr_valid high together");

   // Three synchronizer flops between the two resets
   reset_stretch: assert property (@(posedge afu_clk) bb_softreset |-> ##3 afu_softreset)
      else $error("afu_softreset low three cycles after bb_softreset was high");

endmodule

// File: tests/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen (
   output logic bb_clk,
   output logic afu_clk,
   output logic bb_softreset
);

   // Host clock, 20 ns
   initial begin
      bb_clk = 1'b0;
      forever #10 bb_clk = ~bb_clk;
   end

   // Accelerator clock, 14 ns
   initial begin
      afu_clk = 1'b0;
      forever #7 afu_clk = ~afu_clk;
   end

   initial begin
      bb_softreset = 1'b1;
      repeat (8) @(posedge bb_clk);
      bb_softreset <= 1'b0;
   end

endmodule

// File: source/async_shim_top.sv
`timescale 1ns/1ps

`include "shim_cfg.svh"

module async_shim_top (
   input  logic                     bb_clk,
   input  logic                     bb_softreset,
   input  logic                     afu_clk,
   input  logic                     bb_c0_almfull,
   input  logic                     bb_rsp_valid,
   input  logic                     bb_mmio_wr_valid,
   input  shim_pkg::rsp_hdr_u       bb_rsp_hdr,
   input  logic [`SHIM_DATA_W-1:0]  bb_rsp_data,
   input  logic                     afu_c0_req_valid,
   input  shim_pkg::req_hdr_t       afu_c0_req_hdr,
   output logic                     afu_softreset,
   output logic                     bb_c0_req_valid,
   output shim_pkg::req_hdr_t       bb_c0_req_hdr,
   output logic                     afu_c0_almfull,
   output logic                     afu_rsp_valid,
   output logic                     afu_mmio_wr_valid,
   output shim_pkg::rsp_hdr_u       afu_rsp_hdr,
   output logic [`SHIM_DATA_W-1:0]  afu_rsp_data,
   output logic                     req_overflow,
   output logic                     rsp_overflow
);

   localparam int REQ_W = $bits(shim_pkg::req_hdr_t);
   localparam int RSP_W = 1 + $bits(shim_pkg::rsp_hdr_u) + `SHIM_DATA_W;

   afifo_if #(.DATA_WIDTH(REQ_W), .DEPTH_RADIX(`SHIM_REQ_DEPTH_RADIX)) req_if ();
   afifo_if #(.DATA_WIDTH(RSP_W), .DEPTH_RADIX(`SHIM_RSP_DEPTH_RADIX)) rsp_if ();

   afu_side afu_side_i (
      .afu_clk           (afu_clk),
      .bb_softreset      (bb_softreset),
      .afu_c0_req_valid  (afu_c0_req_valid),
      .afu_c0_req_hdr    (afu_c0_req_hdr),
      .afu_softreset     (afu_softreset),
      .afu_c0_almfull    (afu_c0_almfull),
      .afu_rsp_valid     (afu_rsp_valid),
      .afu_mmio_wr_valid (afu_mmio_wr_valid),
      .afu_rsp_hdr       (afu_rsp_hdr),
      .afu_rsp_data      (afu_rsp_data),
      .req_overflow      (req_overflow),
      .req_wr            (req_if.writer),
      .rsp_rd            (rsp_if.reader)
   );

   bb_side bb_side_i (
      .bb_clk            (bb_clk),
      .bb_softreset      (bb_softreset),
      .bb_c0_almfull     (bb_c0_almfull),
      .bb_rsp_valid      (bb_rsp_valid),
      .bb_mmio_wr_valid  (bb_mmio_wr_valid),
      .bb_rsp_hdr        (bb_rsp_hdr),
      .bb_rsp_data       (bb_rsp_data),
      .bb_c0_req_valid   (bb_c0_req_valid),
      .bb_c0_req_hdr     (bb_c0_req_hdr),
      .rsp_overflow      (rsp_overflow),
      .req_rd            (req_if.reader),
      .rsp_wr            (rsp_if.writer)
   );

   // Requests cross from afu_clk into bb_clk
   async_fifo #(.DATA_WIDTH(REQ_W), .DEPTH_RADIX(`SHIM_REQ_DEPTH_RADIX)) req_fifo_i (
      .wr_clk (afu_clk),
      .wr_rst (afu_softreset),
      .rd_clk (bb_clk),
      .rd_rst (bb_softreset),
      .fifo   (req_if.fifo)
   );

   // Responses and MMIO writes cross back into afu_clk
   async_fifo #(.DATA_WIDTH(RSP_W), .DEPTH_RADIX(`SHIM_RSP_DEPTH_RADIX)) rsp_fifo_i (
      .wr_clk (bb_clk),
      .wr_rst (bb_softreset),
      .rd_clk (afu_clk),
      .rd_rst (afu_softreset),
      .fifo   (rsp_if.fifo)
   );

endmodule

// File: source/bb_side.sv
`timescale 1ns/1ps

`include "shim_cfg.svh"

module bb_side (
   input  logic                     bb_clk,
   input  logic                     bb_softreset,
   input  logic                     bb_c0_almfull,
   input  logic                     bb_rsp_valid,
   input  logic                     bb_mmio_wr_valid,
   input  shim_pkg::rsp_hdr_u       bb_rsp_hdr,
   input  logic [`SHIM_DATA_W-1:0]  bb_rsp_data,
   output logic                     bb_c0_req_valid,
   output shim_pkg::req_hdr_t       bb_c0_req_hdr,
   output logic                     rsp_overflow,
   afifo_if.reader                  req_rd,
   afifo_if.writer                  rsp_wr
);

   logic                     almfull_q;
   logic                     rsp_valid_q;
   logic                     mmio_valid_q;
   shim_pkg::rsp_hdr_u       rsp_hdr_q;
   logic [`SHIM_DATA_W-1:0]  rsp_data_q;
   logic                     req_rdempty_q;
   logic                     req_rdreq;
   logic                     req_rd_en;

   // Host input port registers
   always_ff @(posedge bb_clk) begin
      if (bb_softreset) begin
         almfull_q    <= 1'b0;
         rsp_valid_q  <= 1'b0;
         mmio_valid_q <= 1'b0;
      end else begin
         almfull_q    <= bb_c0_almfull;
         rsp_valid_q  <= bb_rsp_valid;
         mmio_valid_q <= bb_mmio_wr_valid;
      end
   end

   always_ff @(posedge bb_clk) begin
      rsp_hdr_q  <= bb_rsp_hdr;
      rsp_data_q <= bb_rsp_data;
   end

   // Kind bit is set for MMIO writes
   assign rsp_wr.wrreq = rsp_valid_q | mmio_valid_q;
   assign rsp_wr.data  = {mmio_valid_q, rsp_hdr_q, rsp_data_q};

   // Request pump
   // rdreq may run one cycle past the last entry, the FIFO ignores it when empty
   assign req_rd_en    = req_rdreq & ~req_rd.rdempty;
   assign req_rd.rdreq = req_rdreq;

   always_ff @(posedge bb_clk) begin
      if (bb_softreset) begin
         req_rdempty_q   <= 1'b1;
         req_rdreq       <= 1'b0;
         bb_c0_req_valid <= 1'b0;
         rsp_overflow    <= 1'b0;
      end else begin
         req_rdempty_q   <= req_rd.rdempty;
         req_rdreq       <= ~almfull_q & ~req_rdempty_q;
         bb_c0_req_valid <= req_rd_en;
         rsp_overflow    <= rsp_wr.wrreq & rsp_wr.wrfull;
      end
   end

   // FIFO output is registered and holds until the next read
   assign bb_c0_req_hdr = req_rd.q;

endmodule

// File: source/afu_side.sv
`timescale 1ns/1ps

`include "shim_cfg.svh"

module afu_side (
   input  logic                     afu_clk,
   input  logic                     bb_softreset,
   input  logic                     afu_c0_req_valid,
   input  shim_pkg::req_hdr_t       afu_c0_req_hdr,
   output logic                     afu_softreset,
   output logic                     afu_c0_almfull,
   output logic                     afu_rsp_valid,
   output logic                     afu_mmio_wr_valid,
   output shim_pkg::rsp_hdr_u       afu_rsp_hdr,
   output logic [`SHIM_DATA_W-1:0]  afu_rsp_data,
   output logic                     req_overflow,
   afifo_if.writer                  req_wr,
   afifo_if.reader                  rsp_rd
);

   // Outstanding reads allowed before almost-full is forced
   localparam int CREDIT_LIMIT = (2 ** `SHIM_RSP_DEPTH_RADIX) -
                                 `SHIM_ALMFULL_THRESHOLD * `SHIM_CREDIT_MULT;
   localparam int CNT_W        = `SHIM_RSP_DEPTH_RADIX + 1;

   logic                     rst_s1;
   logic                     rst_s2;
   logic                     req_valid_q;
   shim_pkg::req_hdr_t       req_hdr_q;
   logic                     rsp_rdreq;
   logic                     rsp_pending;
   logic                     q_mmio;
   shim_pkg::rsp_hdr_u       q_hdr;
   logic [`SHIM_DATA_W-1:0]  q_data;
   logic [CNT_W-1:0]         credit_cnt;

   // Three-stage reset synchronizer into afu_clk
   always_ff @(posedge afu_clk) begin
      rst_s1        <= bb_softreset;
      rst_s2        <= rst_s1;
      afu_softreset <= rst_s2;
   end

   // Accelerator request port register
   always_ff @(posedge afu_clk) begin
      if (afu_softreset) begin
         req_valid_q <= 1'b0;
      end else begin
         req_valid_q <= afu_c0_req_valid;
      end
   end

   always_ff @(posedge afu_clk) begin
      req_hdr_q <= afu_c0_req_hdr;
   end

   assign req_wr.wrreq = req_valid_q;
   assign req_wr.data  = req_hdr_q;

   // Response FIFO entry is kind, header, data
   assign {q_mmio, q_hdr, q_data} = rsp_rd.q;
   assign rsp_rd.rdreq            = rsp_rdreq;

   always_ff @(posedge afu_clk) begin
      if (afu_softreset) begin
         rsp_rdreq         <= 1'b0;
         rsp_pending       <= 1'b0;
         afu_rsp_valid     <= 1'b0;
         afu_mmio_wr_valid <= 1'b0;
         req_overflow      <= 1'b0;
      end else begin
         rsp_rdreq         <= ~rsp_rd.rdempty;
         rsp_pending       <= rsp_rdreq & ~rsp_rd.rdempty;
         afu_rsp_valid     <= rsp_pending & ~q_mmio;
         afu_mmio_wr_valid <= rsp_pending & q_mmio;
         // Request dropped by a full FIFO
         req_overflow      <= req_valid_q & req_wr.wrfull;
      end
   end

   always_ff @(posedge afu_clk) begin
      if (rsp_pending) begin
         afu_rsp_hdr  <= q_hdr;
         afu_rsp_data <= q_data;
      end
   end

   // Outstanding read credits; MMIO writes leave the count alone
   always_ff @(posedge afu_clk) begin
      if (afu_softreset) begin
         credit_cnt <= '0;
      end else begin
         case ({req_valid_q, afu_rsp_valid})
            2'b10: credit_cnt <= credit_cnt + 1'b1;
            2'b01: begin
               // Floor at zero for responses with no matching request
               if (credit_cnt != '0) begin
                  credit_cnt <= credit_cnt - 1'b1;
               end
            end
            default: credit_cnt <= credit_cnt;
         endcase
      end
   end

   // A full FIFO wraps the used count to zero, so full is added in
   always_ff @(posedge afu_clk) begin
      if (afu_softreset) begin
         afu_c0_almfull <= 1'b0;
      end else begin
         afu_c0_almfull <= req_wr.wrusedw[`SHIM_REQ_DEPTH_RADIX-1] ||
                           req_wr.wrfull ||
                           (credit_cnt > CNT_W'(CREDIT_LIMIT));
      end
   end

endmodule

// File: source/async_fifo.sv
`timescale 1ns/1ps

module async_fifo #(
   parameter int DATA_WIDTH  = 8,
   parameter int DEPTH_RADIX = 4
) (
   input logic   wr_clk,
   input logic   wr_rst,
   input logic   rd_clk,
   input logic   rd_rst,
   afifo_if.fifo fifo
);

   localparam int DEPTH = 2 ** DEPTH_RADIX;

   logic [DATA_WIDTH-1:0]  mem [DEPTH];

   // Pointers carry one extra bit to tell full from empty
   logic [DEPTH_RADIX:0]   wr_bin;
   logic [DEPTH_RADIX:0]   wr_bin_next;
   logic [DEPTH_RADIX:0]   wr_gray;
   logic [DEPTH_RADIX:0]   rd_gray_s1;
   logic [DEPTH_RADIX:0]   rd_gray_s2;
   logic [DEPTH_RADIX:0]   rd_bin_w;
   logic [DEPTH_RADIX:0]   used;
   logic                   wr_en;

   logic [DEPTH_RADIX:0]   rd_bin;
   logic [DEPTH_RADIX:0]   rd_bin_next;
   logic [DEPTH_RADIX:0]   rd_gray;
   logic [DEPTH_RADIX:0]   wr_gray_s1;
   logic [DEPTH_RADIX:0]   wr_gray_s2;
   logic                   rd_en;

   function automatic logic [DEPTH_RADIX:0] bin2gray(input logic [DEPTH_RADIX:0] b);
      return b ^ (b >> 1);
   endfunction

   function automatic logic [DEPTH_RADIX:0] gray2bin(input logic [DEPTH_RADIX:0] g);
      logic [DEPTH_RADIX:0] b;
      b[DEPTH_RADIX] = g[DEPTH_RADIX];
      for (int i = DEPTH_RADIX - 1; i >= 0; i--) begin
         b[i] = b[i+1] ^ g[i];
      end
      return b;
   endfunction

   // Write side: usage is measured against the synchronized read pointer
   assign rd_bin_w     = gray2bin(rd_gray_s2);
   assign used         = wr_bin - rd_bin_w;
   assign fifo.wrfull  = used[DEPTH_RADIX];
   assign fifo.wrusedw = used[DEPTH_RADIX-1:0];
   assign wr_en        = fifo.wrreq & ~fifo.wrfull;
   assign wr_bin_next  = wr_bin + {{DEPTH_RADIX{1'b0}}, wr_en};

   always_ff @(posedge wr_clk) begin
      if (wr_en) begin
         mem[wr_bin[DEPTH_RADIX-1:0]] <= fifo.data;
      end
   end

   always_ff @(posedge wr_clk) begin
      if (wr_rst) begin
         wr_bin     <= '0;
         wr_gray    <= '0;
         rd_gray_s1 <= '0;
         rd_gray_s2 <= '0;
      end else begin
         wr_bin     <= wr_bin_next;
         wr_gray    <= bin2gray(wr_bin_next);
         rd_gray_s1 <= rd_gray;
         rd_gray_s2 <= rd_gray_s1;
      end
   end

   // Read side
   assign rd_en       = fifo.rdreq & ~fifo.rdempty;
   assign rd_bin_next = rd_bin + {{DEPTH_RADIX{1'b0}}, rd_en};

   always_ff @(posedge rd_clk) begin
      if (rd_rst) begin
         rd_bin       <= '0;
         rd_gray      <= '0;
         wr_gray_s1   <= '0;
         wr_gray_s2   <= '0;
         fifo.rdempty <= 1'b1;
      end else begin
         rd_bin       <= rd_bin_next;
         rd_gray      <= bin2gray(rd_bin_next);
         wr_gray_s1   <= wr_gray;
         wr_gray_s2   <= wr_gray_s1;
         // Empty once the advanced read pointer catches the write pointer
         fifo.rdempty <= (bin2gray(rd_bin_next) == wr_gray_s2);
      end
   end

   always_ff @(posedge rd_clk) begin
      if (rd_en) begin
         fifo.q <= mem[rd_bin[DEPTH_RADIX-1:0]];
      end
   end

endmodule

// File: source/afifo_if.sv
`timescale 1ns/1ps

interface afifo_if #(
   parameter int DATA_WIDTH  = 8,
   parameter int DEPTH_RADIX = 4
);

   // Write domain
   logic [DATA_WIDTH-1:0]  data;
   logic                   wrreq;
   logic                   wrfull;
   logic [DEPTH_RADIX-1:0] wrusedw;

   // Read domain
   logic                   rdreq;
   logic [DATA_WIDTH-1:0]  q;
   logic                   rdempty;

   modport writer (
      output data, wrreq,
      input  wrfull, wrusedw
   );

   modport reader (
      output rdreq,
      input  q, rdempty
   );

   modport fifo (
      input  data, wrreq, rdreq,
      output wrfull, wrusedw, q, rdempty
   );

endinterface

// File: source/shim_pkg.sv
package shim_pkg;

`include "shim_cfg.svh"

   // Read request header, accelerator to host
   typedef struct packed {
      logic [`SHIM_TAG_W-1:0]  tag;
      logic [`SHIM_ADDR_W-1:0] addr;
   } req_hdr_t;

   // Memory read response view of the response header
   typedef struct packed {
      logic [`SHIM_TAG_W-1:0]         tag;
      logic [1:0]                     cl_num;
      logic [`SHIM_MMIO_ADDR_W-3:0]   reserved;
   } mem_rsp_hdr_t;

   // MMIO write request view of the same word
   typedef struct packed {
      logic [`SHIM_TAG_W-1:0]       tid;
      logic [`SHIM_MMIO_ADDR_W-1:0] mmio_addr;
   } mmio_req_hdr_t;

   // Kind bit travelling beside the header selects the view
   typedef union packed {
      mem_rsp_hdr_t  mem;
      mmio_req_hdr_t mmio;
   } rsp_hdr_u;

endpackage

// File: source/shim_cfg.svh
`ifndef SHIM_CFG_SVH
`define SHIM_CFG_SVH

// FIFO depths as powers of two
`define SHIM_REQ_DEPTH_RADIX 4
`define SHIM_RSP_DEPTH_RADIX 5

// Header and payload field widths
`define SHIM_ADDR_W 16
`define SHIM_TAG_W 8
`define SHIM_DATA_W 32
`define SHIM_MMIO_ADDR_W 12

// Requests the accelerator may still issue once almost-full is raised
`define SHIM_ALMFULL_THRESHOLD 2

// Safety margin on the threshold when sizing the credit limit
`define SHIM_CREDIT_MULT 8

`endif
